//--- rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

`define XLEN      64
`define REG_COUNT 32
// illegal encodings restart here
`define RESET_PC  64'h0000_0000_8000_0000

`endif

//--- rv_decode_pkg.sv
package rv_decode_pkg;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b,
        // 32-bit word ops, result sign-extended by execute
        alu_addw,
        alu_subw,
        alu_sllw,
        alu_srlw,
        alu_sraw
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_reg,
        src1_pc,
        src1_zero
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_reg,
        src2_imm,
        src2_four
    } src2_sel_e;

    typedef enum logic [3:0] {
        npc_seq,
        npc_jal,
        npc_jalr,
        npc_beq,
        npc_bne,
        npc_blt,
        npc_bge,
        npc_bltu,
        npc_bgeu,
        npc_trap
    } next_pc_sel_e;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc_plus4
    } rf_res_sel_e;

    // encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word,
        size_dword
    } mem_size_e;

    typedef struct packed {
        alu_op_e     alu_op;
        rf_res_sel_e rf_res_sel;
        logic        rf_we;
        logic        mem_ena;
        logic        mem_wen;
        mem_size_e   mem_size;
        logic        mem_unsigned;
    } exe_ctrl_t;

endpackage

//--- decode_ctrl_if.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

interface decode_ctrl_if;
    import rv_decode_pkg::*;

    src1_sel_e          src1_sel;
    src2_sel_e          src2_sel;
    next_pc_sel_e       next_pc_sel;
    // already sign-extended
    logic [`XLEN-1:0]   imm;

    modport producer (
        output src1_sel,
        output src2_sel,
        output next_pc_sel,
        output imm
    );

    modport consumer (
        input src1_sel,
        input src2_sel,
        input next_pc_sel,
        input imm
    );

endinterface

//--- control_unit.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module control_unit (
    input  logic [31:0]               inst,
    output rv_decode_pkg::exe_ctrl_t  exe_ctrl,
    decode_ctrl_if.producer           ctrl,
    output logic                      sys,
    output logic                      illegal
);
    import rv_decode_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32  = 7'b0111011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [31:0] EBREAK    = 32'h0010_0073;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // shared by OP and OP-IMM, alt picks sub or sra
    function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  base_op = alt ? alu_sub : alu_add;
            3'b001:  base_op = alu_sll;
            3'b010:  base_op = alu_slt;
            3'b011:  base_op = alu_sltu;
            3'b100:  base_op = alu_xor;
            3'b101:  base_op = alu_alt_shift(alt);
            3'b110:  base_op = alu_or;
            default: base_op = alu_and;
        endcase
    endfunction

    function automatic alu_op_e alu_alt_shift(input logic alt);
        alu_alt_shift = alt ? alu_sra : alu_srl;
    endfunction

    always_comb begin
        exe_ctrl.alu_op       = alu_add;
        exe_ctrl.rf_res_sel   = res_alu;
        exe_ctrl.rf_we        = 1'b0;
        exe_ctrl.mem_ena      = 1'b0;
        exe_ctrl.mem_wen      = 1'b0;
        exe_ctrl.mem_size     = size_dword;
        exe_ctrl.mem_unsigned = 1'b0;
        ctrl.src1_sel         = src1_reg;
        ctrl.src2_sel         = src2_reg;
        ctrl.next_pc_sel      = npc_seq;
        ctrl.imm              = imm_i;
        sys                   = 1'b0;
        illegal               = 1'b0;

        case (opcode)
            OPC_LUI: begin
                ctrl.src1_sel  = src1_zero;
                ctrl.src2_sel  = src2_imm;
                ctrl.imm       = imm_u;
                exe_ctrl.rf_we = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.src1_sel  = src1_pc;
                ctrl.src2_sel  = src2_imm;
                ctrl.imm       = imm_u;
                exe_ctrl.rf_we = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                // link value pc+4 goes through the ALU
                ctrl.src1_sel       = src1_pc;
                ctrl.src2_sel       = src2_four;
                exe_ctrl.rf_res_sel = res_pc_plus4;
                exe_ctrl.rf_we      = 1'b1;
                if (opcode == OPC_JAL) begin
                    ctrl.imm         = imm_j;
                    ctrl.next_pc_sel = npc_jal;
                end else begin
                    ctrl.next_pc_sel = npc_jalr;
                    illegal          = (funct3 != 3'b000);
                end
            end
            OPC_BRANCH: begin
                ctrl.imm        = imm_b;
                exe_ctrl.alu_op = alu_sub;
                case (funct3)
                    3'b000:  ctrl.next_pc_sel = npc_beq;
                    3'b001:  ctrl.next_pc_sel = npc_bne;
                    3'b100:  ctrl.next_pc_sel = npc_blt;
                    3'b101:  ctrl.next_pc_sel = npc_bge;
                    3'b110:  ctrl.next_pc_sel = npc_bltu;
                    3'b111:  ctrl.next_pc_sel = npc_bgeu;
                    default: illegal          = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                ctrl.src2_sel         = src2_imm;
                exe_ctrl.rf_res_sel   = res_mem;
                exe_ctrl.rf_we        = 1'b1;
                exe_ctrl.mem_ena      = 1'b1;
                exe_ctrl.mem_size     = mem_size_e'(funct3[1:0]);
                exe_ctrl.mem_unsigned = funct3[2];
                // no ldu
                illegal               = (funct3 == 3'b111);
            end
            OPC_STORE: begin
                ctrl.src2_sel     = src2_imm;
                ctrl.imm          = imm_s;
                exe_ctrl.mem_ena  = 1'b1;
                exe_ctrl.mem_wen  = 1'b1;
                exe_ctrl.mem_size = mem_size_e'(funct3[1:0]);
                illegal           = funct3[2];
            end
            OPC_OP_IMM: begin
                ctrl.src2_sel   = src2_imm;
                exe_ctrl.rf_we  = 1'b1;
                exe_ctrl.alu_op = base_op(funct3, (funct3 == 3'b101) && inst[30]);
                // 6-bit shamt, upper bits fixed
                if (funct3 == 3'b001) begin
                    illegal = (inst[31:26] != 6'b000000);
                end else if (funct3 == 3'b101) begin
                    illegal = (inst[31:26] != 6'b000000) && (inst[31:26] != 6'b010000);
                end
            end
            OPC_OP: begin
                exe_ctrl.rf_we  = 1'b1;
                exe_ctrl.alu_op = base_op(funct3, funct7[5]);
                if (funct7 == 7'b0100000) begin
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    illegal = (funct7 != 7'b0000000);
                end
            end
            OPC_IMM_32, OPC_OP_32: begin
                exe_ctrl.rf_we = 1'b1;
                if (opcode == OPC_IMM_32) begin
                    ctrl.src2_sel = src2_imm;
                end
                case (funct3)
                    3'b000: begin
                        exe_ctrl.alu_op = (opcode == OPC_OP_32 && funct7[5]) ? alu_subw
                                                                             : alu_addw;
                        if (opcode == OPC_OP_32) begin
                            illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                        end
                    end
                    3'b001: begin
                        exe_ctrl.alu_op = alu_sllw;
                        illegal         = (funct7 != 7'b0000000);
                    end
                    3'b101: begin
                        exe_ctrl.alu_op = funct7[5] ? alu_sraw : alu_srlw;
                        illegal         = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OPC_SYSTEM: begin
                sys     = (inst == EBREAK);
                illegal = (inst != EBREAK);
            end
            default: illegal = 1'b1;
        endcase

        // unknown encodings must not touch state
        if (illegal) begin
            ctrl.next_pc_sel = npc_trap;
            exe_ctrl.rf_we   = 1'b0;
            exe_ctrl.mem_ena = 1'b0;
            exe_ctrl.mem_wen = 1'b0;
        end
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module reg_file (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [4:0]       raddr1,
    input  logic [4:0]       raddr2,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2,
    input  logic [4:0]       waddr,
    input  logic [`XLEN-1:0] wdata,
    input  logic             we
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // no write-through, new data shows after the edge
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- operand_gen.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module operand_gen (
    decode_ctrl_if.consumer  ctrl,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rdata1,
    input  logic [`XLEN-1:0] rdata2,
    output logic [`XLEN-1:0] alu_src1,
    output logic [`XLEN-1:0] alu_src2
);
    import rv_decode_pkg::*;

    // lui is zero+imm, auipc pc+imm
    always_comb begin
        case (ctrl.src1_sel)
            src1_reg:  alu_src1 = rdata1;
            src1_pc:   alu_src1 = pc;
            default:   alu_src1 = '0;
        endcase
    end

    // four feeds the jal/jalr link value
    always_comb begin
        case (ctrl.src2_sel)
            src2_reg:  alu_src2 = rdata2;
            src2_imm:  alu_src2 = ctrl.imm;
            src2_four: alu_src2 = `XLEN'd4;
            default:   alu_src2 = '0;
        endcase
    end

endmodule

//--- next_pc_unit.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module next_pc_unit (
    decode_ctrl_if.consumer  ctrl,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rdata1,
    input  logic [`XLEN-1:0] rdata2,
    output logic [`XLEN-1:0] next_pc
);
    import rv_decode_pkg::*;

    logic [`XLEN:0]   diff;
    logic             eq;
    logic             lt;
    logic             ltu;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] pc_imm;
    logic [`XLEN-1:0] jalr_sum;

    // top bit of the widened difference is the borrow
    assign diff = {1'b0, rdata1} - {1'b0, rdata2};
    assign eq   = (diff[`XLEN-1:0] == '0);
    assign ltu  = diff[`XLEN];
    // signs differ, rs1 negative means less
    assign lt   = (rdata1[`XLEN-1] != rdata2[`XLEN-1]) ? rdata1[`XLEN-1] : diff[`XLEN-1];

    assign pc_plus4 = pc + `XLEN'd4;
    assign pc_imm   = pc + ctrl.imm;
    assign jalr_sum = rdata1 + ctrl.imm;

    always_comb begin
        case (ctrl.next_pc_sel)
            npc_seq:  next_pc = pc_plus4;
            npc_jal:  next_pc = pc_imm;
            npc_jalr: next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
            npc_beq:  next_pc = eq ? pc_imm : pc_plus4;
            npc_bne:  next_pc = eq ? pc_plus4 : pc_imm;
            npc_blt:  next_pc = lt ? pc_imm : pc_plus4;
            npc_bge:  next_pc = lt ? pc_plus4 : pc_imm;
            npc_bltu: next_pc = ltu ? pc_imm : pc_plus4;
            npc_bgeu: next_pc = ltu ? pc_plus4 : pc_imm;
            default:  next_pc = `RESET_PC;
        endcase
    end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`XLEN-1:0]         pc,
    input  logic [31:0]              inst,
    input  logic [`XLEN-1:0]         rf_wdata,
    input  logic [4:0]               rf_waddr,
    input  logic                     rf_we,
    output rv_decode_pkg::exe_ctrl_t exe_ctrl,
    output logic [4:0]               rd_addr,
    output logic [`XLEN-1:0]         alu_src1,
    output logic [`XLEN-1:0]         alu_src2,
    output logic [`XLEN-1:0]         store_data,
    output logic [`XLEN-1:0]         next_pc,
    output logic                     sys,
    output logic                     illegal
);

    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] rf_rdata1;
    logic [`XLEN-1:0] rf_rdata2;

    decode_ctrl_if ctrl_bus ();

    assign rs1        = inst[19:15];
    assign rs2        = inst[24:20];
    assign rd_addr    = inst[11:7];
    assign store_data = rf_rdata2;

    control_unit u_control_unit (
        .inst     (inst),
        .exe_ctrl (exe_ctrl),
        .ctrl     (ctrl_bus.producer),
        .sys      (sys),
        .illegal  (illegal)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .we     (rf_we)
    );

    operand_gen u_operand_gen (
        .ctrl     (ctrl_bus.consumer),
        .pc       (pc),
        .rdata1   (rf_rdata1),
        .rdata2   (rf_rdata2),
        .alu_src1 (alu_src1),
        .alu_src2 (alu_src2)
    );

    next_pc_unit u_next_pc_unit (
        .ctrl    (ctrl_bus.consumer),
        .pc      (pc),
        .rdata1  (rf_rdata1),
        .rdata2  (rf_rdata2),
        .next_pc (next_pc)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the write edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- tb_decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module tb_decode_stage;
    import rv_decode_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int REPS       = 4;
    localparam int CLK_PERIOD = 10;
    // 20 cycles per test and repetition
    localparam int WATCHDOG_CYCLES = 20 * NUM_TESTS * REPS;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    // beq bne blt bge bltu bgeu, lowest first
    localparam logic [17:0] BR_F3 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

    logic             clk;
    logic             arst_n;
    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
    logic [`XLEN-1:0] rf_wdata;
    logic [4:0]       rf_waddr;
    logic             rf_we;
    exe_ctrl_t        exe_ctrl;
    logic [4:0]       rd_addr;
    logic [`XLEN-1:0] alu_src1;
    logic [`XLEN-1:0] alu_src2;
    logic [`XLEN-1:0] store_data;
    logic [`XLEN-1:0] next_pc;
    logic             sys;
    logic             illegal;

    // expected register contents
    logic [`XLEN-1:0] model [0:31];
    string            cur_test;
    int               errors;
    int               err_mark;
    int               tests_passed;
    int               tests_failed;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    decode_stage i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc         (pc),
        .inst       (inst),
        .rf_wdata   (rf_wdata),
        .rf_waddr   (rf_waddr),
        .rf_we      (rf_we),
        .exe_ctrl   (exe_ctrl),
        .rd_addr    (rd_addr),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .store_data (store_data),
        .next_pc    (next_pc),
        .sys        (sys),
        .illegal    (illegal)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        r_type = {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        i_type = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [63:0] sext(input logic [63:0] x, input int bits);
        logic [63:0] sh;
        sh = x << (64 - bits);
        sext = $signed(sh) >>> (64 - bits);
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] t;
        t = 1 + ($urandom % 31);
        rand_reg = t[4:0];
    endfunction

    function automatic logic [63:0] rand_pc();
        logic [63:0] p;
        p = {$urandom, $urandom};
        rand_pc = {p[63:2], 2'b00};
    endfunction

    // lb/lbu/sb byte, lh/lhu/sh half, lw/lwu/sw word, ld/sd dword
    function automatic mem_size_e access_size(input logic [2:0] f3);
        case (f3)
            3'd0, 3'd4: access_size = size_byte;
            3'd1, 3'd5: access_size = size_half;
            3'd2, 3'd6: access_size = size_word;
            default:    access_size = size_dword;
        endcase
    endfunction

    function automatic exe_ctrl_t make_ctrl(input alu_op_e op, input rf_res_sel_e res,
                                            input logic we, input logic ena, input logic wen,
                                            input mem_size_e size, input logic uns);
        exe_ctrl_t c;
        c.alu_op       = op;
        c.rf_res_sel   = res;
        c.rf_we        = we;
        c.mem_ena      = ena;
        c.mem_wen      = wen;
        c.mem_size     = size;
        c.mem_unsigned = uns;
        make_ctrl = c;
    endfunction

    task automatic check_word(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    // size and signedness mean nothing while memory is off
    task automatic check_ctrl(input string what, input exe_ctrl_t exp, input exe_ctrl_t act);
        exe_ctrl_t a;
        a = act;
        if (!exp.mem_ena) begin
            a.mem_size     = exp.mem_size;
            a.mem_unsigned = exp.mem_unsigned;
        end
        if (a !== exp) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", cur_test, errors - err_mark);
        end
    endtask

    task automatic apply_inst(input logic [31:0] i, input logic [63:0] p);
        @(negedge clk);
        inst  = i;
        pc    = p;
        rf_we = 1'b0;
        #2;
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [63:0] val);
        @(negedge clk);
        rf_we    = 1'b1;
        rf_waddr = idx;
        rf_wdata = val;
        @(negedge clk);
        rf_we = 1'b0;
        if (idx != 5'd0) begin
            model[idx] = val;
        end
    endtask

    task automatic reg_file_access();
        int          other;
        logic [63:0] v;
        begin_test("reg_file");
        for (int r = 0; r < 32; r++) begin
            apply_inst(r_type(7'd0, r[4:0], r[4:0], 3'd0, 5'd1, OPC_OP), 64'd0);
            check_word($sformatf("x%0d rs1 after reset", r), 64'd0, alu_src1);
            check_word($sformatf("x%0d rs2 after reset", r), 64'd0, store_data);
        end
        for (int r = 1; r < 32; r++) begin
            write_reg(r[4:0], {$urandom, $urandom});
        end
        write_reg(5'd0, {$urandom, $urandom});
        for (int r = 0; r < 32; r++) begin
            other = 31 - r;
            apply_inst(r_type(7'd0, other[4:0], r[4:0], 3'd0, 5'd1, OPC_OP), 64'd0);
            check_word($sformatf("x%0d rs1", r), model[r], alu_src1);
            check_word($sformatf("x%0d rs2", other), model[other], store_data);
        end
        // new data only after the rising edge
        v = {$urandom, $urandom};
        @(negedge clk);
        inst     = r_type(7'd0, 5'd0, 5'd5, 3'd0, 5'd1, OPC_OP);
        rf_we    = 1'b1;
        rf_waddr = 5'd5;
        rf_wdata = v;
        #2;
        check_word("x5 before edge", model[5], alu_src1);
        @(posedge clk);
        #1;
        check_word("x5 after edge", v, alu_src1);
        model[5] = v;
        @(negedge clk);
        rf_we = 1'b0;
        end_test();
    endtask

    task automatic alu_operands();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [63:0] p;
        begin_test("alu_ops");
        for (int n = 0; n < REPS; n++) begin
            rs1 = rand_reg();
            rs2 = rand_reg();
            rd  = rand_reg();
            imm = $urandom;
            p   = rand_pc();
            apply_inst(i_type(imm[11:0], rs1, 3'd0, rd, OPC_OP_IMM), p);
            check_word("addi src1", model[rs1], alu_src1);
            check_word("addi src2", sext({52'd0, imm[11:0]}, 12), alu_src2);
            check_word("addi rd", {59'd0, rd}, {59'd0, rd_addr});
            check_ctrl("addi ctrl", make_ctrl(alu_add, res_alu, 1, 0, 0, size_dword, 0),
                       exe_ctrl);
            apply_inst(r_type(7'h20, rs2, rs1, 3'd0, rd, OPC_OP), p);
            check_word("sub src1", model[rs1], alu_src1);
            check_word("sub src2", model[rs2], alu_src2);
            check_ctrl("sub ctrl", make_ctrl(alu_sub, res_alu, 1, 0, 0, size_dword, 0),
                       exe_ctrl);
            apply_inst({imm[31:12], rd, OPC_LUI}, p);
            check_word("lui src1", 64'd0, alu_src1);
            check_word("lui src2", sext({32'd0, imm[31:12], 12'd0}, 32), alu_src2);
            check_ctrl("lui ctrl", make_ctrl(alu_add, res_alu, 1, 0, 0, size_dword, 0),
                       exe_ctrl);
            apply_inst({imm[31:12], rd, OPC_AUIPC}, p);
            check_word("auipc src1", p, alu_src1);
            check_word("auipc src2", sext({32'd0, imm[31:12], 12'd0}, 32), alu_src2);
            check_ctrl("auipc ctrl", make_ctrl(alu_add, res_alu, 1, 0, 0, size_dword, 0),
                       exe_ctrl);
        end
        end_test();
    endtask

    task automatic branch_targets();
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rnd;
        logic [12:0] imm;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] p;
        logic        taken;
        begin_test("branches");
        for (int k = 0; k < 6; k++) begin
            f3 = BR_F3[3*k +: 3];
            for (int n = 0; n < REPS; n++) begin
                rs1 = rand_reg();
                // first pass compares a register with itself
                rs2 = (n == 0) ? rs1 : rand_reg();
                rnd = $urandom;
                imm = {rnd[11:0], 1'b0};
                p   = rand_pc();
                a   = model[rs1];
                b   = model[rs2];
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                apply_inst(b_type(imm, rs2, rs1, f3), p);
                check_word($sformatf("branch f3=%0d next_pc", f3),
                           taken ? p + sext({51'd0, imm}, 13) : p + 64'd4, next_pc);
            end
        end
        end_test();
    endtask

    task automatic jump_targets();
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [31:0] rnd;
        logic [63:0] p;
        logic [63:0] target;
        exe_ctrl_t   exp;
        begin_test("jumps");
        exp = make_ctrl(alu_add, res_pc_plus4, 1, 0, 0, size_dword, 0);
        for (int n = 0; n < REPS; n++) begin
            rs1 = rand_reg();
            rd  = rand_reg();
            rnd = $urandom;
            p   = rand_pc();
            apply_inst(j_type({rnd[19:0], 1'b0}, rd), p);
            check_word("jal next_pc", p + sext({43'd0, rnd[19:0], 1'b0}, 21), next_pc);
            check_word("jal link", p + 64'd4, alu_src1 + alu_src2);
            check_ctrl("jal ctrl", exp, exe_ctrl);
            apply_inst(i_type(rnd[31:20], rs1, 3'd0, rd, OPC_JALR), p);
            target = model[rs1] + sext({52'd0, rnd[31:20]}, 12);
            check_word("jalr next_pc", {target[63:1], 1'b0}, next_pc);
            check_word("jalr link", p + 64'd4, alu_src1 + alu_src2);
            check_ctrl("jalr ctrl", exp, exe_ctrl);
        end
        end_test();
    endtask

    task automatic load_store_fields();
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rnd;
        begin_test("load_store");
        // lb lh lw ld lbu lhu lwu
        for (int f = 0; f < 7; f++) begin
            f3  = f[2:0];
            rs1 = rand_reg();
            rnd = $urandom;
            apply_inst(i_type(rnd[11:0], rs1, f3, rand_reg(), OPC_LOAD), rand_pc());
            check_ctrl($sformatf("load f3=%0d ctrl", f3),
                       make_ctrl(alu_add, res_mem, 1, 1, 0, access_size(f3), f >= 4),
                       exe_ctrl);
            check_word($sformatf("load f3=%0d src2", f3), sext({52'd0, rnd[11:0]}, 12),
                       alu_src2);
        end
        for (int f = 0; f < 4; f++) begin
            f3  = f[2:0];
            rs1 = rand_reg();
            rs2 = rand_reg();
            rnd = $urandom;
            apply_inst(s_type(rnd[11:0], rs2, rs1, f3), rand_pc());
            check_ctrl($sformatf("store f3=%0d ctrl", f3),
                       make_ctrl(alu_add, res_alu, 0, 1, 1, access_size(f3), 0),
                       exe_ctrl);
            check_word($sformatf("store f3=%0d src2", f3), sext({52'd0, rnd[11:0]}, 12),
                       alu_src2);
            check_word($sformatf("store f3=%0d data", f3), model[rs2], store_data);
        end
        end_test();
    endtask

    task automatic system_flags();
        logic [31:0] rnd;
        begin_test("system");
        apply_inst(32'h0010_0073, rand_pc());
        check_bit("ebreak sys", 1'b1, sys);
        check_bit("ebreak illegal", 1'b0, illegal);
        // two opcodes outside RV64I
        for (int n = 0; n < 2; n++) begin
            rnd = $urandom;
            apply_inst({rnd[24:0], (n == 0) ? 7'b1111111 : 7'b0001011}, rand_pc());
            check_bit("undefined illegal", 1'b1, illegal);
            check_bit("undefined sys", 1'b0, sys);
            check_word("undefined next_pc", `RESET_PC, next_pc);
            check_bit("undefined rf_we", 1'b0, exe_ctrl.rf_we);
            check_bit("undefined mem_ena", 1'b0, exe_ctrl.mem_ena);
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h2381_b363));
        pc           = '0;
        inst         = 32'h0000_0013;
        rf_wdata     = '0;
        rf_waddr     = '0;
        rf_we        = 1'b0;
        errors       = 0;
        err_mark     = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        @(posedge arst_n);
        reg_file_access();
        alu_operands();
        branch_targets();
        jump_targets();
        load_store_fields();
        system_flags();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
rv_decode_pkg.sv
decode_ctrl_if.sv
control_unit.sv
reg_file.sv
operand_gen.sv
next_pc_unit.sv
decode_stage.sv
tb_clock_gen.sv
tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sources.f --top-module tb_decode_stage \
    --Mdir obj_dir -o sim_decode
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_decode > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
exit 1
